//--- adc_params.svh
`ifndef ADC_PARAMS_SVH
`define ADC_PARAMS_SVH

// sample and stream widths
`define ADC_SAMPLE_W        16   // bits per conversion result
`define ADC_CHANNELS        8    // V1..V8 per chip
`define AXIS_DATA_W         32   // two samples per word
`define CTRL_REG_W          32   // control inputs, error flags

// parallel bus timing in clock cycles
`define CONVST_LOW_CYCLES   2
`define RD_LOW_CYCLES       2    // data sampled in the last low cycle
`define RD_HIGH_CYCLES      1    // gap between channels

// each BUSY wait gives up after this many cycles
`define BUSY_TIMEOUT_CYCLES 200

// words held before the stream side takes them
`define FIFO_DEPTH          16

`endif

//--- ad7606_pkg.sv
`default_nettype none
`include "adc_params.svh"

package ad7606_pkg;

	typedef logic [`ADC_SAMPLE_W-1:0] sample_t;                  // raw DB0..DB15, sign left to user
	typedef logic [$clog2(`ADC_CHANNELS)-1:0] chan_idx_t;      // 0 = V1
	typedef sample_t [`ADC_CHANNELS-1:0] chan_array_t;         // one full conversion

	typedef enum logic [2:0] {
		IDLE,          // waiting for a tick
		CONVST,        // CONVST held low
		WAIT_BUSY_HI,  // conversion accepted once BUSY rises
		WAIT_BUSY_LO,  // conversion running
		RD_LOW,        // RD/CS low, data valid at the end
		RD_HIGH        // gap before the next channel
	} reader_state_t;

endpackage

`default_nettype wire

//--- stream_pkg.sv
`default_nettype none
`include "adc_params.svh"

package stream_pkg;

	typedef logic [`AXIS_DATA_W-1:0] word_t;                    // TDATA payload
	typedef logic [`CTRL_REG_W-1:0] count_t;                    // points and divider
	typedef logic [$clog2(`FIFO_DEPTH):0] fifo_idx_t;         // extra msb tells full from empty

	typedef enum logic {
		IDLE,  // ready for a trigger
		SEND   // ticking and streaming
	} frame_state_t;

endpackage

`default_nettype wire

//--- sample_if.sv
`default_nettype none

interface sample_if;

	ad7606_pkg::chan_array_t channels;  // held from done until next conversion
	logic                    sampling;  // conversion or readout in progress
	logic                    done;      // one cycle, all eight channels valid
	logic                    timeout;   // one cycle, BUSY never moved

	modport reader (output channels, output sampling, output done, output timeout);

	modport packer (input channels, input sampling, input done, input timeout);

endinterface

`default_nettype wire

//--- ad7606_reader.sv
`default_nettype none
`include "adc_params.svh"

module ad7606_reader (
	input  logic                M_AXIS_ACLK,
	input  logic                adc_rst_n,
	input  logic                sample_tick,  // start one conversion
	input  logic                hw_busy,
	input  ad7606_pkg::sample_t hw_data,      // parallel data bus
	output logic                hw_convst,    // low pulse starts conversion
	output logic                hw_rd,        // active low
	output logic                hw_cs,        // active low
	sample_if.reader            res
);

	localparam int CNT_W = $clog2(`BUSY_TIMEOUT_CYCLES + 1);
	localparam logic [CNT_W-1:0] CONVST_LAST  = CNT_W'(`CONVST_LOW_CYCLES - 1);
	localparam logic [CNT_W-1:0] RD_LOW_LAST  = CNT_W'(`RD_LOW_CYCLES - 1);
	localparam logic [CNT_W-1:0] RD_HIGH_LAST = CNT_W'(`RD_HIGH_CYCLES - 1);
	localparam logic [CNT_W-1:0] BUSY_LAST    = CNT_W'(`BUSY_TIMEOUT_CYCLES - 1);
	localparam ad7606_pkg::chan_idx_t LAST_CH = ad7606_pkg::chan_idx_t'(`ADC_CHANNELS - 1);

	ad7606_pkg::reader_state_t state;
	logic [CNT_W-1:0]          cnt;      // cycles spent in current phase
	ad7606_pkg::chan_idx_t     ch;       // channel on the bus
	logic                      capture;  // last RD low cycle

	assign hw_convst = (state != ad7606_pkg::CONVST);
	assign hw_rd     = (state != ad7606_pkg::RD_LOW);
	assign hw_cs     = (state != ad7606_pkg::RD_LOW);  // framed with RD per channel
	assign capture   = (state == ad7606_pkg::RD_LOW) && (cnt == RD_LOW_LAST);

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			state        <= ad7606_pkg::IDLE;
			cnt          <= '0;
			ch           <= '0;
			res.sampling <= 1'b0;
			res.done     <= 1'b0;
			res.timeout  <= 1'b0;
		end else begin
			res.done    <= 1'b0;  // pulses
			res.timeout <= 1'b0;
			cnt         <= cnt + 1'b1;
			case (state)
				ad7606_pkg::IDLE: begin
					cnt <= '0;
					if (sample_tick) begin
						state        <= ad7606_pkg::CONVST;
						res.sampling <= 1'b1;
					end
				end
				ad7606_pkg::CONVST: begin
					if (cnt == CONVST_LAST) begin
						state <= ad7606_pkg::WAIT_BUSY_HI;
						cnt   <= '0;
					end
				end
				ad7606_pkg::WAIT_BUSY_HI: begin
					if (hw_busy) begin
						state <= ad7606_pkg::WAIT_BUSY_LO;
						cnt   <= '0;  // fresh budget for the fall
					end else if (cnt == BUSY_LAST) begin
						state        <= ad7606_pkg::IDLE;
						res.sampling <= 1'b0;
						res.timeout  <= 1'b1;
					end
				end
				ad7606_pkg::WAIT_BUSY_LO: begin
					if (!hw_busy) begin
						state <= ad7606_pkg::RD_LOW;
						cnt   <= '0;
						ch    <= '0;  // V1 first
					end else if (cnt == BUSY_LAST) begin
						state        <= ad7606_pkg::IDLE;
						res.sampling <= 1'b0;
						res.timeout  <= 1'b1;
					end
				end
				ad7606_pkg::RD_LOW: begin
					if (capture) begin
						cnt <= '0;
						if (ch == LAST_CH) begin
							state        <= ad7606_pkg::IDLE;  // no gap after V8
							res.sampling <= 1'b0;
							res.done     <= 1'b1;
						end else begin
							state <= ad7606_pkg::RD_HIGH;
						end
					end
				end
				ad7606_pkg::RD_HIGH: begin
					if (cnt == RD_HIGH_LAST) begin
						state <= ad7606_pkg::RD_LOW;
						cnt   <= '0;
						ch    <= ch + 1'b1;
					end
				end
				default: state <= ad7606_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (capture)
			res.channels[ch] <= hw_data;  // bus settled for RD_LOW_CYCLES
	end

endmodule

`default_nettype wire

//--- sample_packer.sv
`default_nettype none
`include "adc_params.svh"

module sample_packer (
	input  logic                  M_AXIS_ACLK,
	input  logic                  adc_rst_n,
	input  logic                  frame_start,  // flush write state, clear flags
	sample_if.packer              res_a,
	sample_if.packer              res_b,
	input  logic                  full,
	output logic                  wr_en,
	output stream_pkg::word_t     wr_data,
	output logic [`CTRL_REG_W-1:0] error_flags
);

	logic                    done_a, done_b;    // conversion finished since last tick
	logic                    armed_a, armed_b;  // chip seen idle inside this frame
	logic                    writing;
	logic [2:0]              wcnt;              // 0..3 chip A, 4..7 chip B
	logic                    err_a, err_b, ovf;
	ad7606_pkg::chan_array_t src;

	assign src         = wcnt[2] ? res_b.channels : res_a.channels;
	assign wr_data     = {src[{wcnt[1:0], 1'b1}], src[{wcnt[1:0], 1'b0}]};  // even ch high
	assign wr_en       = writing;
	assign error_flags = {{(`CTRL_REG_W - 3){1'b0}}, ovf, err_b, err_a};

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n || frame_start) begin
			done_a  <= 1'b0;
			done_b  <= 1'b0;
			armed_a <= 1'b0;  // a conversion left over from last frame is dropped
			armed_b <= 1'b0;
			writing <= 1'b0;
			wcnt    <= '0;
			err_a   <= 1'b0;
			err_b   <= 1'b0;
			ovf     <= 1'b0;
		end else begin
			if (!res_a.sampling) armed_a <= 1'b1;
			if (!res_b.sampling) armed_b <= 1'b1;
			if (res_a.sampling) done_a <= 1'b0;  // new tick, stale result
			if (res_b.sampling) done_b <= 1'b0;
			if (writing) begin
				wcnt <= wcnt + 1'b1;
				if (wcnt == 3'd7) begin
					writing <= 1'b0;
					done_a  <= 1'b0;
					done_b  <= 1'b0;
				end
			end else if (done_a && done_b) begin
				writing <= 1'b1;  // wcnt sits at 0 here
			end
			if (res_a.done && armed_a) done_a <= 1'b1;
			if (res_b.done && armed_b) done_b <= 1'b1;
			err_a <= err_a | res_a.timeout;  // sticky
			err_b <= err_b | res_b.timeout;
			ovf   <= ovf | (writing && full);
		end
	end

endmodule

`default_nettype wire

//--- stream_fifo.sv
`default_nettype none
`include "adc_params.svh"

module stream_fifo (
	input  logic              M_AXIS_ACLK,
	input  logic              adc_rst_n,
	input  logic              frame_start,  // flush
	input  logic              wr_en,
	input  stream_pkg::word_t wr_data,
	output logic              full,
	input  logic              stream_en,    // frame in SEND
	input  logic              tready,
	output logic              tvalid,
	output stream_pkg::word_t tdata
);

	localparam int AW = $clog2(`FIFO_DEPTH);

	stream_pkg::word_t     mem [`FIFO_DEPTH];
	stream_pkg::fifo_idx_t wr_ptr;
	stream_pkg::fifo_idx_t rd_ptr;
	logic                  empty;
	logic                  push;
	logic                  pop;

	assign empty  = (wr_ptr == rd_ptr);
	assign full   = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign push   = wr_en && !full;  // dropped write is flagged by the packer
	assign tvalid = !empty && stream_en;
	assign pop    = tvalid && tready;
	assign tdata  = mem[rd_ptr[AW-1:0]];  // head word, held until popped

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n || frame_start) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

endmodule

`default_nettype wire

//--- frame_sequencer.sv
`default_nettype none

module frame_sequencer (
	input  logic               M_AXIS_ACLK,
	input  logic               adc_rst_n,
	input  logic               trigger,                 // async, rising edge starts a frame
	input  stream_pkg::count_t sampling_clk_increment,  // half the tick period
	input  stream_pkg::count_t sampling_points,         // words per frame
	input  logic               last_frame,
	input  logic               tvalid,
	input  logic               tready,
	output logic               tlast,
	output logic               ready,
	output logic               frame_start,
	output logic               stream_en,
	output logic               sample_tick
);

	stream_pkg::frame_state_t state;
	logic                     trig_meta, trig_sync, trig_prev;
	logic                     trig_rise;
	stream_pkg::count_t       points_q, incr_q;  // frozen for the frame
	logic                     last_q;
	stream_pkg::count_t       period;
	stream_pkg::count_t       div_cnt;
	stream_pkg::count_t       hs_cnt;            // words accepted so far
	logic                     hs, at_last, last_hs, wrap;

	assign trig_rise   = trig_sync && !trig_prev;
	assign ready       = (state == stream_pkg::IDLE);
	assign stream_en   = (state == stream_pkg::SEND);
	assign frame_start = ready && trig_rise;  // same edge that enters SEND
	assign period      = incr_q << 1;
	assign wrap        = (div_cnt == period - 1'b1);
	assign hs          = stream_en && tvalid && tready;
	assign at_last     = (hs_cnt == points_q - 1'b1);
	assign last_hs     = hs && at_last;
	assign tlast       = stream_en && last_q && at_last;

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			trig_meta <= 1'b0;
			trig_sync <= 1'b0;
			trig_prev <= 1'b0;
		end else begin
			trig_meta <= trigger;
			trig_sync <= trig_meta;
			trig_prev <= trig_sync;  // edge detect
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (frame_start) begin
			points_q <= sampling_points;
			incr_q   <= sampling_clk_increment;
			last_q   <= last_frame;
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			state       <= stream_pkg::IDLE;
			div_cnt     <= '0;
			hs_cnt      <= '0;
			sample_tick <= 1'b0;
		end else begin
			case (state)
				stream_pkg::IDLE: begin
					div_cnt     <= '0;
					hs_cnt      <= '0;
					sample_tick <= 1'b0;
					if (trig_rise) state <= stream_pkg::SEND;
				end
				stream_pkg::SEND: begin
					sample_tick <= wrap && !last_hs;  // first one a full period in
					div_cnt     <= wrap ? '0 : div_cnt + 1'b1;
					if (hs) hs_cnt <= hs_cnt + 1'b1;
					if (last_hs) state <= stream_pkg::IDLE;
				end
				default: state <= stream_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- adc_stream_top.sv
`default_nettype none
`include "adc_params.svh"

module adc_stream_top (
	input  logic                    adc_a_hw_busy,
	input  ad7606_pkg::sample_t     adc_a_hw_data,
	output logic                    adc_a_hw_convst,
	output logic                    adc_a_hw_rd,
	output logic                    adc_a_hw_cs,
	input  logic                    adc_b_hw_busy,
	input  ad7606_pkg::sample_t     adc_b_hw_data,
	output logic                    adc_b_hw_convst,  // tied to A on the board
	output logic                    adc_b_hw_rd,
	output logic                    adc_b_hw_cs,
	input  stream_pkg::count_t      sampling_clk_increment,
	input  stream_pkg::count_t      sampling_points,
	input  logic                    last_frame,
	input  logic                    one_frame_sampling_trigger,
	input  logic                    M_AXIS_ACLK,
	input  logic                    adc_rst_n,
	output logic                    M_AXIS_TVALID,
	output stream_pkg::word_t       M_AXIS_TDATA,
	output logic                    M_AXIS_TLAST,
	input  logic                    M_AXIS_TREADY,
	output logic [`CTRL_REG_W-1:0]  error_flags,  // 0 A timeout, 1 B timeout, 2 overflow
	output logic                    ready
);

	logic              sample_tick, frame_start, stream_en;
	logic              wr_en, full;
	stream_pkg::word_t wr_data;

	sample_if res_a ();
	sample_if res_b ();

	ad7606_reader u_reader_a (.M_AXIS_ACLK, .adc_rst_n, .sample_tick,
		.hw_busy(adc_a_hw_busy), .hw_data(adc_a_hw_data), .hw_convst(adc_a_hw_convst),
		.hw_rd(adc_a_hw_rd), .hw_cs(adc_a_hw_cs), .res(res_a.reader));

	ad7606_reader u_reader_b (.M_AXIS_ACLK, .adc_rst_n, .sample_tick,
		.hw_busy(adc_b_hw_busy), .hw_data(adc_b_hw_data), .hw_convst(adc_b_hw_convst),
		.hw_rd(adc_b_hw_rd), .hw_cs(adc_b_hw_cs), .res(res_b.reader));

	sample_packer u_packer (.M_AXIS_ACLK, .adc_rst_n, .frame_start,
		.res_a(res_a.packer), .res_b(res_b.packer), .full, .wr_en, .wr_data, .error_flags);

	stream_fifo u_fifo (.M_AXIS_ACLK, .adc_rst_n, .frame_start, .wr_en, .wr_data, .full,
		.stream_en, .tready(M_AXIS_TREADY), .tvalid(M_AXIS_TVALID), .tdata(M_AXIS_TDATA));

	frame_sequencer u_seq (.M_AXIS_ACLK, .adc_rst_n, .trigger(one_frame_sampling_trigger),
		.sampling_clk_increment, .sampling_points, .last_frame, .tvalid(M_AXIS_TVALID),
		.tready(M_AXIS_TREADY), .tlast(M_AXIS_TLAST), .ready, .frame_start, .stream_en,
		.sample_tick);

endmodule

`default_nettype wire

//--- tb_adc_stream.sv
`default_nettype none
`include "adc_params.svh"

module tb_adc_stream;

	localparam int NROWS = 5;

	logic                       M_AXIS_ACLK = 1'b0;
	logic                       adc_rst_n = 1'b0;
	logic                       trigger = 1'b0;
	logic                       last_frame = 1'b0;
	logic                       tready = 1'b1;
	stream_pkg::count_t         incr = '0;
	stream_pkg::count_t         points = '0;
	logic [1:0]                 busy = '0;    // bit 0 chip A, bit 1 chip B
	ad7606_pkg::sample_t [1:0]  data = '0;
	logic [1:0]                 convst, rd, cs, convst_q = '1, rd_q = '1;
	logic [1:0]                 stuck = '0;   // hold BUSY high
	int                         conv_cnt [2] = '{0, 0};
	int                         busy_left [2] = '{0, 0};
	int                         rd_idx [2] = '{0, 0};
	logic                       tvalid, tlast, ready;
	stream_pkg::word_t          tdata;
	logic [`CTRL_REG_W-1:0]     error_flags;

	// name, increment, points, last_frame, stall, chip B stuck
	string row_name [NROWS]   = '{"basic16", "tlast16", "stall16", "b_stuck", "recover8"};
	int    row_incr [NROWS]   = '{40, 40, 40, 40, 35};
	int    row_points [NROWS] = '{16, 16, 16, 4, 8};
	bit    row_last [NROWS]   = '{0, 1, 1, 0, 1};
	bit    row_stall [NROWS]  = '{0, 0, 1, 0, 1};
	bit    row_stuck [NROWS]  = '{0, 0, 0, 1, 0};

	adc_stream_top u_dut (
		.adc_a_hw_busy(busy[0]), .adc_a_hw_data(data[0]), .adc_a_hw_convst(convst[0]),
		.adc_a_hw_rd(rd[0]), .adc_a_hw_cs(cs[0]),
		.adc_b_hw_busy(busy[1]), .adc_b_hw_data(data[1]), .adc_b_hw_convst(convst[1]),
		.adc_b_hw_rd(rd[1]), .adc_b_hw_cs(cs[1]),
		.sampling_clk_increment(incr), .sampling_points(points), .last_frame,
		.one_frame_sampling_trigger(trigger), .M_AXIS_ACLK, .adc_rst_n,
		.M_AXIS_TVALID(tvalid), .M_AXIS_TDATA(tdata), .M_AXIS_TLAST(tlast),
		.M_AXIS_TREADY(tready), .error_flags, .ready);

	always #50 M_AXIS_ACLK = ~M_AXIS_ACLK;

	function automatic ad7606_pkg::sample_t sample_value(int chip, int conv, int ch);
		return ad7606_pkg::sample_t'(chip * 32'h8000 + conv * 16 + ch);  // ch is 1..8
	endfunction

	// k 0..3 from chip A, 4..7 from chip B, even channel on top
	function automatic stream_pkg::word_t packed_word(int conv_a, int conv_b, int k);
		int chip;
		int conv;
		chip = k / 4;
		conv = (chip == 0) ? conv_a : conv_b;
		return {sample_value(chip, conv, 2 * (k % 4) + 2),
			sample_value(chip, conv, 2 * (k % 4) + 1)};
	endfunction

	// two chip models, BUSY after CONVST falls, next channel on each RD fall while CS is low
	always @(posedge M_AXIS_ACLK) begin
		convst_q <= convst;
		rd_q     <= rd;
		for (int c = 0; c < 2; c++) begin
			if (convst_q[c] && !convst[c]) begin
				conv_cnt[c]  <= conv_cnt[c] + 1;
				busy_left[c] <= 5 + int'($urandom % 16);  // 5..20 cycles
				rd_idx[c]    <= 0;
				busy[c]      <= 1'b1;
			end else if (busy_left[c] > 0) begin
				busy_left[c] <= busy_left[c] - 1;
			end else if (!stuck[c]) begin
				busy[c] <= 1'b0;
			end
			if (rd_q[c] && !rd[c] && !cs[c]) begin  // bus only answers a selected chip
				data[c]   <= sample_value(c, conv_cnt[c], rd_idx[c] + 1);
				rd_idx[c] <= rd_idx[c] + 1;
			end
		end
	end

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic stop_on_timeout(string what);
		$display("timeout while waiting for %s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic apply_reset();
		@(posedge M_AXIS_ACLK);
		adc_rst_n <= 1'b0;
		stuck     <= 2'b00;
		repeat (8) @(posedge M_AXIS_ACLK);
		adc_rst_n <= 1'b1;
		@(negedge M_AXIS_ACLK);
		// ready, tvalid, tlast, then convst rd cs of both chips
		check_value("reset outputs", 32'h13f, {23'd0, ready, tvalid, tlast, convst, rd, cs});
	endtask

	task automatic run_row(int r);
		int n;
		int cycles;
		int limit;
		int snap_a;
		int snap_b;
		logic held;                    // tvalid high and tready low last cycle
		stream_pkg::word_t held_data;
		string tag;
		tag  = row_name[r];
		n    = 0;
		held = 1'b0;
		@(posedge M_AXIS_ACLK);
		incr       <= row_incr[r];
		points     <= row_points[r];
		last_frame <= row_last[r];
		stuck      <= {row_stuck[r], 1'b0};
		tready     <= 1'b1;
		trigger    <= 1'b1;
		snap_a = conv_cnt[0];  // no conversion starts while idle
		snap_b = conv_cnt[1];
		cycles = 0;
		do begin
			@(negedge M_AXIS_ACLK);
			cycles++;
			if (cycles > 20) stop_on_timeout({tag, " ready to fall after the trigger"});
		end while (ready);
		check_value({tag, " flags cleared"}, 32'd0, error_flags);
		cycles = 0;
		limit  = row_stuck[r] ? 1500 : 3000;
		while (!ready && cycles < limit) begin
			@(posedge M_AXIS_ACLK);
			trigger <= 1'b0;
			if (row_stall[r]) tready <= ($urandom % 3) != 0;
			@(negedge M_AXIS_ACLK);
			cycles++;
			if (held) begin
				check_value({tag, " tvalid held"}, 32'd1, 32'(tvalid));
				check_value({tag, " tdata held"}, held_data, tdata);
			end
			// high only while the last word is due, and only for a last frame
			check_value($sformatf("%s tlast %0d", tag, n),
				32'(row_last[r] && (n == row_points[r] - 1)), 32'(tlast));
			if (tvalid && tready) begin
				check_value($sformatf("%s word %0d", tag, n),
					packed_word(snap_a + 1 + n / 8, snap_b + 1 + n / 8, n % 8), tdata);
				n++;
			end
			held      = tvalid && !tready;
			held_data = tdata;
		end
		if (row_stuck[r]) begin  // frame never completes
			check_value({tag, " ready"}, 32'd0, 32'(ready));
			check_value({tag, " words"}, 32'd0, 32'(n));
			check_value({tag, " error_flags"}, 32'h2, error_flags);
			apply_reset();
		end else if (!ready) begin
			stop_on_timeout({tag, " ready to return at frame end"});
		end else begin
			check_value({tag, " words"}, 32'(row_points[r]), 32'(n));
			check_value({tag, " timeout flags"}, 32'd0, 32'(error_flags[1:0]));
		end
	endtask

	initial begin
		int seed;
		seed = $urandom(32'hc2099ef5);
		apply_reset();
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
ad7606_pkg.sv
stream_pkg.sv
sample_if.sv
ad7606_reader.sv
sample_packer.sv
stream_fifo.sv
frame_sequencer.sv
adc_stream_top.sv
tb_adc_stream.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f flist.f --top-module tb_adc_stream -o sim_adc_stream
./obj_dir/sim_adc_stream > sim.log 2>&1 || true
cat sim.log
if grep -q "^Result: PASSED$" sim.log; then
	echo "simulation run ok"
else
	echo "simulation run not ok, see sim.log"
	exit 1
fi
